/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_int_core
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sources.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/core_ifs.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/int_core.sv
testbench/tb_int_core.sv

/* testbench/tb_int_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module tb_int_core;
    import core_pkg::*;

    localparam int    MAX_STEPS      = 64;
    localparam int    TIMEOUT_CYCLES = 200;
    localparam int    KIND_ALU       = 0;
    localparam int    KIND_BR        = 1;
    localparam int    KIND_ILL       = 2;
    localparam word_t BASE_PC        = 32'h1c00_0000;

    logic     clk          = 1'b0;
    logic     rst_n        = 1'b0;
    logic     in_valid     = 1'b0;
    word_t    in_pc        = '0;
    word_t    in_inst      = '0;
    logic     in_ready;
    logic     out_valid;
    logic     out_ready    = 1'b0;
    word_t    out_pc;
    reg_idx_t out_dest;
    word_t    out_value;
    logic     out_br_taken;
    word_t    out_br_target;
    logic     out_illegal;
    logic     random_ready = 1'b0;

    // Step table, one column per array.
    string    step_name  [MAX_STEPS];
    word_t    step_inst  [MAX_STEPS];
    int       step_kind  [MAX_STEPS];
    reg_idx_t step_dest  [MAX_STEPS];
    word_t    step_value [MAX_STEPS];
    logic     step_taken [MAX_STEPS];
    word_t    step_offs  [MAX_STEPS];   // Byte offset from pc to the branch target.
    int       step_count  = 0;
    int       mismatches  = 0;
    int       pass_count  = 0;
    int       fail_count  = 0;
    logic     timeout_hit = 1'b0;

    int_core int_core_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_pc         (in_pc),
        .in_inst       (in_inst),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_pc        (out_pc),
        .out_dest      (out_dest),
        .out_value     (out_value),
        .out_br_taken  (out_br_taken),
        .out_br_target (out_br_target),
        .out_illegal   (out_illegal)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        out_ready <= random_ready ? 1'($urandom % 2) : 1'b1;
    end

    // --------------------------------------------------
    // Instruction encoders
    function automatic word_t r3_inst(input logic [16:0] op, input reg_idx_t rd,
                                      input reg_idx_t rj, input reg_idx_t rk);
        return {op, rk, rj, rd};   // Shift immediates sit in the rk field.
    endfunction

    function automatic word_t i12_inst(input logic [9:0] op, input reg_idx_t rd,
                                       input reg_idx_t rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic word_t lu12i_inst(input reg_idx_t rd, input logic [19:0] imm);
        return {`OP_LU12I_W, imm, rd};
    endfunction

    function automatic word_t br_inst(input logic [5:0] op, input reg_idx_t rj,
                                      input reg_idx_t rd, input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic word_t b_inst(input logic [25:0] offs);
        return {`OP_B, offs[15:0], offs[25:16]};
    endfunction

    function automatic word_t pc_of(input int idx);
        return BASE_PC + word_t'(idx) * 32'd4;
    endfunction

    // --------------------------------------------------
    // Table construction
    task automatic add_step(input string name, input word_t inst, input int kind,
                            input reg_idx_t dest, input word_t value, input logic taken,
                            input word_t offs);
        step_name[step_count]  = name;
        step_inst[step_count]  = inst;
        step_kind[step_count]  = kind;
        step_dest[step_count]  = dest;
        step_value[step_count] = value;
        step_taken[step_count] = taken;
        step_offs[step_count]  = offs;
        step_count++;
    endtask

    task automatic alu_step(input string name, input word_t inst, input reg_idx_t dest,
                            input word_t value);
        add_step(name, inst, KIND_ALU, dest, value, 1'b0, '0);
    endtask

    task automatic br_step(input string name, input word_t inst, input logic taken,
                           input int offs);
        add_step(name, inst, KIND_BR, '0, '0, taken, word_t'(offs));
    endtask

    task automatic ill_step(input string name, input word_t inst);
        add_step(name, inst, KIND_ILL, '0, '0, 1'b0, '0);
    endtask

    task automatic build_table();
        alu_step("addi_w",     i12_inst(`OP_ADDI_W, 5'd1, 5'd0, 12'h123), 5'd1, 32'h0000_0123);
        alu_step("addi_w_neg", i12_inst(`OP_ADDI_W, 5'd2, 5'd0, 12'hffb), 5'd2, 32'hffff_fffb);
        alu_step("ori_zext",   i12_inst(`OP_ORI, 5'd3, 5'd0, 12'h800),    5'd3, 32'h0000_0800);
        alu_step("lu12i_w",    lu12i_inst(5'd4, 20'h12345),               5'd4, 32'h1234_5000);
        // Each of these reads the result of the one before it.
        alu_step("add_w_fwd",  r3_inst(`OP_ADD_W, 5'd5, 5'd4, 5'd1),   5'd5,  32'h1234_5123);
        alu_step("sub_w_fwd",  r3_inst(`OP_SUB_W, 5'd6, 5'd5, 5'd2),   5'd6,  32'h1234_5128);
        alu_step("and_fwd",    r3_inst(`OP_AND, 5'd7, 5'd6, 5'd4),     5'd7,  32'h1234_5000);
        alu_step("or_fwd",     r3_inst(`OP_OR, 5'd8, 5'd7, 5'd1),      5'd8,  32'h1234_5123);
        alu_step("nor_fwd",    r3_inst(`OP_NOR, 5'd9, 5'd8, 5'd3),     5'd9,  32'hedcb_a6dc);
        alu_step("xor_fwd",    r3_inst(`OP_XOR, 5'd10, 5'd9, 5'd8),    5'd10, 32'hffff_f7ff);
        alu_step("slli_w",     r3_inst(`OP_SLLI_W, 5'd11, 5'd2, 5'd4),  5'd11, 32'hffff_ffb0);
        alu_step("srli_w",     r3_inst(`OP_SRLI_W, 5'd12, 5'd11, 5'd8), 5'd12, 32'h00ff_ffff);
        alu_step("srai_w",     r3_inst(`OP_SRAI_W, 5'd13, 5'd11, 5'd8), 5'd13, 32'hffff_ffff);
        alu_step("addi_shamt", i12_inst(`OP_ADDI_W, 5'd14, 5'd0, 12'h024), 5'd14, 32'h0000_0024);
        alu_step("sll_w",      r3_inst(`OP_SLL_W, 5'd15, 5'd4, 5'd14), 5'd15, 32'h2345_0000);
        alu_step("srl_w",      r3_inst(`OP_SRL_W, 5'd16, 5'd9, 5'd14), 5'd16, 32'h0edc_ba6d);
        alu_step("sra_w",      r3_inst(`OP_SRA_W, 5'd17, 5'd9, 5'd14), 5'd17, 32'hfedc_ba6d);
        alu_step("slt_neg",    r3_inst(`OP_SLT, 5'd18, 5'd2, 5'd1),    5'd18, 32'h0000_0001);
        alu_step("sltu_neg",   r3_inst(`OP_SLTU, 5'd19, 5'd2, 5'd1),   5'd19, 32'h0000_0000);
        alu_step("slti_neg",   i12_inst(`OP_SLTI, 5'd20, 5'd2, 12'hffc),  5'd20, 32'h0000_0001);
        alu_step("sltui_max",  i12_inst(`OP_SLTUI, 5'd21, 5'd1, 12'hfff), 5'd21, 32'h0000_0001);
        alu_step("sltui_neg",  i12_inst(`OP_SLTUI, 5'd22, 5'd2, 12'h005), 5'd22, 32'h0000_0000);
        // Branches: r1 = 0x123, r2 = -5, r3 = 0x800.
        br_step("beq_taken",  br_inst(`OP_BEQ, 5'd1, 5'd1, 16'h0010),  1'b1, 64);
        br_step("beq_not",    br_inst(`OP_BEQ, 5'd1, 5'd3, 16'h0010),  1'b0, 64);
        br_step("bne_taken",  br_inst(`OP_BNE, 5'd1, 5'd3, 16'hfffc),  1'b1, -16);
        br_step("bne_not",    br_inst(`OP_BNE, 5'd1, 5'd1, 16'hfffc),  1'b0, -16);
        br_step("blt_taken",  br_inst(`OP_BLT, 5'd2, 5'd1, 16'h0008),  1'b1, 32);
        br_step("blt_not",    br_inst(`OP_BLT, 5'd1, 5'd2, 16'h0008),  1'b0, 32);
        br_step("bge_taken",  br_inst(`OP_BGE, 5'd1, 5'd2, 16'h0020),  1'b1, 128);
        br_step("bge_not",    br_inst(`OP_BGE, 5'd2, 5'd1, 16'h0020),  1'b0, 128);
        br_step("bltu_taken", br_inst(`OP_BLTU, 5'd1, 5'd2, 16'h0004), 1'b1, 16);
        br_step("bltu_not",   br_inst(`OP_BLTU, 5'd2, 5'd1, 16'h0004), 1'b0, 16);
        br_step("bgeu_taken", br_inst(`OP_BGEU, 5'd2, 5'd1, 16'h0100), 1'b1, 1024);
        br_step("bgeu_not",   br_inst(`OP_BGEU, 5'd1, 5'd2, 16'h0100), 1'b0, 1024);
        br_step("b_back",     b_inst(26'h3ff_fff8),                    1'b1, -32);
        ill_step("illegal",   32'hfc00_0003);
        alu_step("addi_r0",   i12_inst(`OP_ADDI_W, 5'd0, 5'd1, 12'h005), 5'd0, 32'h0000_0128);
        alu_step("read_r0",   r3_inst(`OP_ADD_W, 5'd23, 5'd0, 5'd1),     5'd23, 32'h0000_0123);
    endtask

    // --------------------------------------------------
    // Compare and report
    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected r%0d, actual r%0d", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %0b, actual %0b", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (mismatches == errs_before) begin
            pass_count++;
            $display("[PASS] %s", name);
        end else begin
            fail_count++;
            $display("[DONE] %s, %0d field(s) wrong", name, mismatches - errs_before);
        end
    endtask

    task automatic report_timeout(input string what, input string name);
        if (!timeout_hit) begin
            $display("Timed out after %0d cycles waiting for the %s of step %s.",
                     TIMEOUT_CYCLES, what, name);
        end
        timeout_hit = 1'b1;
    endtask

    // --------------------------------------------------
    // Driver and monitor
    task automatic drive_steps();
        int cycles;
        for (int i = 0; i < step_count && !timeout_hit; i++) begin
            in_valid <= 1'b1;
            in_pc    <= pc_of(i);
            in_inst  <= step_inst[i];
            cycles = 0;
            @(negedge clk);
            while (!in_ready && cycles < TIMEOUT_CYCLES && !timeout_hit) begin
                cycles++;
                @(negedge clk);
            end
            if (!in_ready) begin
                report_timeout("input handshake", step_name[i]);
            end
            @(posedge clk);   // The transfer happens on this edge.
        end
        in_valid <= 1'b0;
    endtask

    task automatic check_results(input string pass_name);
        int    cycles;
        int    errs_before;
        string tag;
        for (int j = 0; j < step_count && !timeout_hit; j++) begin
            cycles = 0;
            @(negedge clk);
            while (!(out_valid && out_ready) && cycles < TIMEOUT_CYCLES && !timeout_hit) begin
                cycles++;
                @(negedge clk);
            end
            if (out_valid && out_ready) begin
                tag = {pass_name, "/", step_name[j]};
                errs_before = mismatches;
                check_word({tag, ".pc"}, pc_of(j), out_pc);
                check_reg({tag, ".dest"}, step_dest[j], out_dest);
                if (step_kind[j] == KIND_ALU) begin
                    check_word({tag, ".value"}, step_value[j], out_value);
                end
                check_flag({tag, ".br_taken"}, step_taken[j], out_br_taken);
                if (step_kind[j] == KIND_BR) begin
                    check_word({tag, ".br_target"}, pc_of(j) + step_offs[j], out_br_target);
                end
                check_flag({tag, ".illegal"}, step_kind[j] == KIND_ILL, out_illegal);
                finish_test(tag, errs_before);
            end else begin
                report_timeout("result", step_name[j]);
            end
        end
    endtask

    task automatic run_pass(input string pass_name);
        int   errs_before;
        logic extra_seen;
        fork
            drive_steps();
            check_results(pass_name);
        join
        if (!timeout_hit) begin
            extra_seen = 1'b0;
            repeat (8) begin
                @(negedge clk);
                extra_seen = extra_seen | out_valid;   // Any result after the last one is extra.
            end
            errs_before = mismatches;
            check_flag({pass_name, "/drain.out_valid"}, 1'b0, extra_seen);
            check_flag({pass_name, "/drain.in_ready"}, 1'b1, in_ready);
            finish_test({pass_name, "/drain"}, errs_before);
        end
    endtask

    initial begin
        int errs_before;
        void'($urandom(32'h773ab92a));
        build_table();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        errs_before = mismatches;
        check_flag("reset.in_ready", 1'b1, in_ready);
        check_flag("reset.out_valid", 1'b0, out_valid);
        finish_test("reset", errs_before);

        @(posedge clk);
        run_pass("pass1");
        if (!timeout_hit) begin
            @(posedge clk);
            random_ready <= 1'b1;   // Second pass runs with back-pressure on the output.
            run_pass("pass2");
        end

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && !timeout_hit) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define XLEN      32
`define REG_COUNT 32
`define REG_IDX_W 5

// Instruction field slices.
`define F_OP17   31:15
`define F_OP10   31:22
`define F_OP7    31:25
`define F_OP6    31:26
`define F_RD     4:0
`define F_RJ     9:5
`define F_RK     14:10
`define F_UI5    14:10
`define F_I12    21:10
`define F_I16    25:10
`define F_I20    24:5
`define F_I26LO  9:0

// Three-register group and shift-immediate group, matched on bits 31:15.
`define OP_ADD_W   17'h00020
`define OP_SUB_W   17'h00022
`define OP_SLT     17'h00024
`define OP_SLTU    17'h00025
`define OP_NOR     17'h00028
`define OP_AND     17'h00029
`define OP_OR      17'h0002a
`define OP_XOR     17'h0002b
`define OP_SLL_W   17'h0002e
`define OP_SRL_W   17'h0002f
`define OP_SRA_W   17'h00030
`define OP_SLLI_W  17'h00081
`define OP_SRLI_W  17'h00089
`define OP_SRAI_W  17'h00091

// 12-bit immediate group, matched on bits 31:22.
`define OP_SLTI    10'h008
`define OP_SLTUI   10'h009
`define OP_ADDI_W  10'h00a
`define OP_ANDI    10'h00d
`define OP_ORI     10'h00e
`define OP_XORI    10'h00f

`define OP_LU12I_W 7'h0a

// Branches, matched on bits 31:26.
`define OP_B       6'h14
`define OP_BEQ     6'h16
`define OP_BNE     6'h17
`define OP_BLT     6'h18
`define OP_BGE     6'h19
`define OP_BLTU    6'h1a
`define OP_BGEU    6'h1b

`endif

/* verilog/core_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// Decode to execute handshake with the decoded bundle.
interface ex_if;
    import core_pkg::*;

    logic     valid;
    logic     ready;
    word_t    pc;
    alu_op_t  alu_op;
    word_t    src1;
    word_t    src2;
    word_t    rkd_value;
    br_kind_t br_kind;
    word_t    br_target;
    reg_idx_t dest;
    logic     illegal;

    modport source (output valid, pc, alu_op, src1, src2, rkd_value, br_kind,
                    br_target, dest, illegal, input ready);
    modport sink   (input valid, pc, alu_op, src1, src2, rkd_value, br_kind,
                    br_target, dest, illegal, output ready);
endinterface

// Two combinational register file read ports.
interface rf_read_if;
    import core_pkg::*;

    reg_idx_t raddr1;
    reg_idx_t raddr2;
    word_t    rdata1;
    word_t    rdata2;

    modport requester (output raddr1, raddr2, input rdata1, rdata2);
    modport provider  (input raddr1, raddr2, output rdata1, rdata2);
endinterface

`default_nettype wire

/* verilog/core_pkg.sv */
`default_nettype none

`include "core_cfg.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // ALU operation carried from decode to execute.
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLT  = 4'd2,
        SLTU = 4'd3,
        AND  = 4'd4,
        OR   = 4'd5,
        NOR  = 4'd6,
        XOR  = 4'd7,
        SLL  = 4'd8,
        SRL  = 4'd9,
        SRA  = 4'd10,
        LUI  = 4'd11   // Passes the second operand through.
    } alu_op_t;

    // Branch condition, resolved in execute.
    typedef enum logic [2:0] {
        NONE   = 3'd0,
        EQ     = 3'd1,
        NE     = 3'd2,
        LT     = 3'd3,
        GE     = 3'd4,
        LTU    = 3'd5,
        GEU    = 3'd6,
        ALWAYS = 3'd7
    } br_kind_t;

endpackage

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module decode_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    in_valid,
    input  wire core_pkg::word_t   in_pc,
    input  wire core_pkg::word_t   in_inst,
    output logic                   in_ready,
    ex_if.source                   ex,
    rf_read_if.requester           rf,
    input  wire                    ex_fwd_valid,
    input  wire core_pkg::reg_idx_t ex_fwd_dest,
    input  wire core_pkg::word_t   ex_fwd_value,
    input  wire                    res_fwd_valid,
    input  wire core_pkg::reg_idx_t res_fwd_dest,
    input  wire core_pkg::word_t   res_fwd_value
);
    import core_pkg::*;

    logic        d_valid;
    word_t       d_pc;
    word_t       d_inst;
    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;
    reg_idx_t    rd;
    reg_idx_t    rj;
    reg_idx_t    rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    logic        hit_3r;
    logic        hit_i12;
    logic        hit_br;
    logic        is_lu12i;
    logic        shift_imm;
    logic        zext12;
    logic        legal;
    alu_op_t     alu_op;
    br_kind_t    br_kind;
    word_t       imm;
    word_t       br_offs;
    word_t       rj_value;
    word_t       rkd_value;
    logic        ex_hit1;
    logic        ex_hit2;
    logic        res_hit1;
    logic        res_hit2;

    assign in_ready = ~d_valid | ex.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else if (in_ready) begin
            d_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            d_pc   <= in_pc;
            d_inst <= in_inst;
        end
    end

    // --------------------------------------------------
    // Field extraction and opcode match
    assign op17 = d_inst[`F_OP17];
    assign op10 = d_inst[`F_OP10];
    assign op7  = d_inst[`F_OP7];
    assign op6  = d_inst[`F_OP6];
    assign rd   = d_inst[`F_RD];
    assign rj   = d_inst[`F_RJ];
    assign rk   = d_inst[`F_RK];
    assign i12  = d_inst[`F_I12];
    assign i16  = d_inst[`F_I16];
    assign i20  = d_inst[`F_I20];
    assign i26  = {d_inst[`F_I26LO], d_inst[`F_I16]};

    assign is_lu12i  = (op7 == `OP_LU12I_W);
    assign shift_imm = (op17 == `OP_SLLI_W) || (op17 == `OP_SRLI_W) || (op17 == `OP_SRAI_W);
    assign zext12    = (op10 == `OP_ANDI) || (op10 == `OP_ORI) || (op10 == `OP_XORI);

    // The groups never overlap, so each case only fills in its own hits.
    always_comb begin
        alu_op  = ADD;
        br_kind = NONE;
        hit_3r  = 1'b1;
        hit_i12 = 1'b1;
        hit_br  = 1'b1;
        case (op17)
            `OP_ADD_W:              alu_op = ADD;
            `OP_SUB_W:              alu_op = SUB;
            `OP_SLT:                alu_op = SLT;
            `OP_SLTU:               alu_op = SLTU;
            `OP_NOR:                alu_op = NOR;
            `OP_AND:                alu_op = AND;
            `OP_OR:                 alu_op = OR;
            `OP_XOR:                alu_op = XOR;
            `OP_SLL_W, `OP_SLLI_W:  alu_op = SLL;
            `OP_SRL_W, `OP_SRLI_W:  alu_op = SRL;
            `OP_SRA_W, `OP_SRAI_W:  alu_op = SRA;
            default:                hit_3r = 1'b0;
        endcase
        case (op10)
            `OP_SLTI:   alu_op = SLT;
            `OP_SLTUI:  alu_op = SLTU;
            `OP_ADDI_W: alu_op = ADD;
            `OP_ANDI:   alu_op = AND;
            `OP_ORI:    alu_op = OR;
            `OP_XORI:   alu_op = XOR;
            default:    hit_i12 = 1'b0;
        endcase
        case (op6)
            `OP_B:    br_kind = ALWAYS;
            `OP_BEQ:  br_kind = EQ;
            `OP_BNE:  br_kind = NE;
            `OP_BLT:  br_kind = LT;
            `OP_BGE:  br_kind = GE;
            `OP_BLTU: br_kind = LTU;
            `OP_BGEU: br_kind = GEU;
            default:  hit_br = 1'b0;
        endcase
        if (is_lu12i) begin
            alu_op = LUI;
        end
    end

    assign legal = hit_3r | hit_i12 | hit_br | is_lu12i;

    assign imm = is_lu12i  ? {i20, 12'b0} :
                 shift_imm ? {27'b0, d_inst[`F_UI5]} :
                 zext12    ? {20'b0, i12} :
                             {{20{i12[11]}}, i12};

    assign br_offs = (br_kind == ALWAYS) ? {{4{i26[25]}}, i26, 2'b0} :
                                           {{14{i16[15]}}, i16, 2'b0};

    // --------------------------------------------------
    // Operand read and forwarding
    assign rf.raddr1 = rj;
    assign rf.raddr2 = hit_br ? rd : rk;   // Branches compare rj with rd.

    assign ex_hit1  = ex_fwd_valid  && (ex_fwd_dest  != '0) && (ex_fwd_dest  == rf.raddr1);
    assign ex_hit2  = ex_fwd_valid  && (ex_fwd_dest  != '0) && (ex_fwd_dest  == rf.raddr2);
    assign res_hit1 = res_fwd_valid && (res_fwd_dest != '0) && (res_fwd_dest == rf.raddr1);
    assign res_hit2 = res_fwd_valid && (res_fwd_dest != '0) && (res_fwd_dest == rf.raddr2);

    assign rj_value  = ex_hit1 ? ex_fwd_value : res_hit1 ? res_fwd_value : rf.rdata1;
    assign rkd_value = ex_hit2 ? ex_fwd_value : res_hit2 ? res_fwd_value : rf.rdata2;

    assign ex.valid     = d_valid;
    assign ex.pc        = d_pc;
    assign ex.alu_op    = alu_op;
    assign ex.src1      = rj_value;
    assign ex.src2      = (shift_imm || hit_i12 || is_lu12i) ? imm : rkd_value;
    assign ex.rkd_value = rkd_value;
    assign ex.br_kind   = br_kind;
    assign ex.br_target = hit_br ? d_pc + br_offs : '0;
    assign ex.dest      = (legal && !hit_br) ? rd : '0;   // Zero means no write.
    assign ex.illegal   = ~legal;

    input_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> $stable(in_pc) && $stable(in_inst))
        else $error("Input pc or instruction changed before it was accepted.");

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                     clk,
    input  wire                     rst_n,
    ex_if.sink                      ex,
    output logic                    ex_fwd_valid,
    output core_pkg::reg_idx_t      ex_fwd_dest,
    output core_pkg::word_t         ex_fwd_value,
    output logic                    res_valid,
    input  wire                     res_ready,
    output core_pkg::word_t         res_pc,
    output core_pkg::reg_idx_t      res_dest,
    output core_pkg::word_t         res_value,
    output logic                    res_br_taken,
    output core_pkg::word_t         res_br_target,
    output logic                    res_illegal
);
    import core_pkg::*;

    logic       e_valid;
    word_t      e_pc;
    alu_op_t    e_alu_op;
    word_t      e_src1;
    word_t      e_src2;
    word_t      e_rkd;
    br_kind_t   e_br_kind;
    word_t      e_br_target;
    reg_idx_t   e_dest;
    logic       e_illegal;
    logic [4:0] shamt;
    word_t      alu_result;
    logic       src_eq;
    logic       src_lt;
    logic       src_ltu;
    logic       br_taken;

    assign ex.ready = ~e_valid | res_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_valid <= 1'b0;
        end else if (ex.ready) begin
            e_valid <= ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex.valid && ex.ready) begin
            e_pc        <= ex.pc;
            e_alu_op    <= ex.alu_op;
            e_src1      <= ex.src1;
            e_src2      <= ex.src2;
            e_rkd       <= ex.rkd_value;
            e_br_kind   <= ex.br_kind;
            e_br_target <= ex.br_target;
            e_dest      <= ex.dest;
            e_illegal   <= ex.illegal;
        end
    end

    // --------------------------------------------------
    // ALU
    assign shamt = e_src2[4:0];

    always_comb begin
        case (e_alu_op)
            ADD:     alu_result = e_src1 + e_src2;
            SUB:     alu_result = e_src1 - e_src2;
            SLT:     alu_result = word_t'($signed(e_src1) < $signed(e_src2));
            SLTU:    alu_result = word_t'(e_src1 < e_src2);
            AND:     alu_result = e_src1 & e_src2;
            OR:      alu_result = e_src1 | e_src2;
            NOR:     alu_result = ~(e_src1 | e_src2);
            XOR:     alu_result = e_src1 ^ e_src2;
            SLL:     alu_result = e_src1 << shamt;
            SRL:     alu_result = e_src1 >> shamt;
            SRA:     alu_result = $signed(e_src1) >>> shamt;
            LUI:     alu_result = e_src2;
            default: alu_result = '0;
        endcase
    end

    // Branch compare against the second register value, not the ALU operand.
    assign src_eq  = (e_src1 == e_rkd);
    assign src_lt  = $signed(e_src1) < $signed(e_rkd);
    assign src_ltu = e_src1 < e_rkd;

    always_comb begin
        case (e_br_kind)
            EQ:      br_taken = src_eq;
            NE:      br_taken = ~src_eq;
            LT:      br_taken = src_lt;
            GE:      br_taken = ~src_lt;
            LTU:     br_taken = src_ltu;
            GEU:     br_taken = ~src_ltu;
            ALWAYS:  br_taken = 1'b1;
            default: br_taken = 1'b0;
        endcase
    end

    assign ex_fwd_valid  = e_valid;
    assign ex_fwd_dest   = e_dest;
    assign ex_fwd_value  = alu_result;

    assign res_valid     = e_valid;
    assign res_pc        = e_pc;
    assign res_dest      = e_dest;
    assign res_value     = alu_result;
    assign res_br_taken  = br_taken;
    assign res_br_target = e_br_target;
    assign res_illegal   = e_illegal;

    alu_op_known_a: assert property (@(posedge clk) disable iff (!rst_n)
        e_valid |-> !$isunknown(e_alu_op))
        else $error("Execute stage holds an unknown ALU operation.");

endmodule

`default_nettype wire

/* verilog/int_core.sv */
`timescale 1ns/1ps
`default_nettype none

module int_core (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     in_valid,
    input  wire core_pkg::word_t    in_pc,
    input  wire core_pkg::word_t    in_inst,
    output logic                    in_ready,
    output logic                    out_valid,
    input  wire                     out_ready,
    output core_pkg::word_t         out_pc,
    output core_pkg::reg_idx_t      out_dest,
    output core_pkg::word_t         out_value,
    output logic                    out_br_taken,
    output core_pkg::word_t         out_br_target,
    output logic                    out_illegal
);
    import core_pkg::*;

    logic     ex_fwd_valid;
    reg_idx_t ex_fwd_dest;
    word_t    ex_fwd_value;
    logic     res_fwd_valid;
    reg_idx_t res_fwd_dest;
    word_t    res_fwd_value;
    logic     res_valid;
    logic     res_ready;
    word_t    res_pc;
    reg_idx_t res_dest;
    word_t    res_value;
    logic     res_br_taken;
    word_t    res_br_target;
    logic     res_illegal;

    ex_if      ex_bus ();
    rf_read_if rf_bus ();

    decode_stage decode_stage_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_pc         (in_pc),
        .in_inst       (in_inst),
        .in_ready      (in_ready),
        .ex            (ex_bus.source),
        .rf            (rf_bus.requester),
        .ex_fwd_valid  (ex_fwd_valid),
        .ex_fwd_dest   (ex_fwd_dest),
        .ex_fwd_value  (ex_fwd_value),
        .res_fwd_valid (res_fwd_valid),
        .res_fwd_dest  (res_fwd_dest),
        .res_fwd_value (res_fwd_value)
    );

    execute_stage execute_stage_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex            (ex_bus.sink),
        .ex_fwd_valid  (ex_fwd_valid),
        .ex_fwd_dest   (ex_fwd_dest),
        .ex_fwd_value  (ex_fwd_value),
        .res_valid     (res_valid),
        .res_ready     (res_ready),
        .res_pc        (res_pc),
        .res_dest      (res_dest),
        .res_value     (res_value),
        .res_br_taken  (res_br_taken),
        .res_br_target (res_br_target),
        .res_illegal   (res_illegal)
    );

    result_stage result_stage_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .res_valid     (res_valid),
        .res_ready     (res_ready),
        .res_pc        (res_pc),
        .res_dest      (res_dest),
        .res_value     (res_value),
        .res_br_taken  (res_br_taken),
        .res_br_target (res_br_target),
        .res_illegal   (res_illegal),
        .rf            (rf_bus.provider),
        .res_fwd_valid (res_fwd_valid),
        .res_fwd_dest  (res_fwd_dest),
        .res_fwd_value (res_fwd_value),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_pc        (out_pc),
        .out_dest      (out_dest),
        .out_value     (out_value),
        .out_br_taken  (out_br_taken),
        .out_br_target (out_br_target),
        .out_illegal   (out_illegal)
    );

endmodule

`default_nettype wire

/* verilog/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module result_stage (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     res_valid,
    output logic                    res_ready,
    input  wire core_pkg::word_t    res_pc,
    input  wire core_pkg::reg_idx_t res_dest,
    input  wire core_pkg::word_t    res_value,
    input  wire                     res_br_taken,
    input  wire core_pkg::word_t    res_br_target,
    input  wire                     res_illegal,
    rf_read_if.provider             rf,
    output logic                    res_fwd_valid,
    output core_pkg::reg_idx_t      res_fwd_dest,
    output core_pkg::word_t         res_fwd_value,
    output logic                    out_valid,
    input  wire                     out_ready,
    output core_pkg::word_t         out_pc,
    output core_pkg::reg_idx_t      out_dest,
    output core_pkg::word_t         out_value,
    output logic                    out_br_taken,
    output core_pkg::word_t         out_br_target,
    output logic                    out_illegal
);
    import core_pkg::*;

    word_t regs [`REG_COUNT];

    assign res_ready = ~out_valid | out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (res_ready) begin
            out_valid <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid && res_ready) begin
            out_pc        <= res_pc;
            out_dest      <= res_dest;
            out_value     <= res_value;
            out_br_taken  <= res_br_taken;
            out_br_target <= res_br_target;
            out_illegal   <= res_illegal;
        end
    end

    // Architectural state changes only when the result is taken.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (out_valid && out_ready && out_dest != '0) begin
            regs[out_dest] <= out_value;
        end
    end

    assign rf.rdata1 = (rf.raddr1 == '0) ? '0 : regs[rf.raddr1];
    assign rf.rdata2 = (rf.raddr2 == '0) ? '0 : regs[rf.raddr2];

    assign res_fwd_valid = out_valid;
    assign res_fwd_dest  = out_dest;
    assign res_fwd_value = out_value;

    out_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable({out_pc, out_dest, out_value,
            out_br_taken, out_br_target, out_illegal}))
        else $error("Result changed while waiting for out_ready.");

endmodule

`default_nettype wire
